// ==== hdl/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

localparam int XLEN = 32;

typedef logic [XLEN-1:0] word_t;
typedef logic [XLEN-1:0] addr_t;
typedef logic [4:0]      reg_idx_t;

typedef enum logic [3:0]
{
    class_lui,
    class_auipc,
    class_jal,
    class_jalr,
    class_branch,
    class_load,
    class_store,
    class_alu_imm,
    class_alu_reg,
    class_wfi,
    class_invalid
} inst_class_e;

typedef enum logic [3:0]
{
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
} alu_op_e;

typedef enum logic [2:0]
{
    br_eq,
    br_ne,
    br_lt,
    br_ge,
    br_ltu,
    br_geu
} br_cond_e;

// rd is zero for classes that write no register
typedef struct packed
{
    inst_class_e inst_class;
    alu_op_e     alu_op;
    br_cond_e    br_cond;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    word_t       imm;
} decoded_t;

// wishbone classic, master to slave
typedef struct packed
{
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    word_t dat;
} wb_m2s_t;

typedef struct packed
{
    logic  ack;
    word_t dat;
} wb_s2m_t;

typedef enum logic [2:0]
{
    state_idle,
    state_fetch,
    state_execute,
    state_load,
    state_store
} core_state_e;

endpackage

`default_nettype wire

// ==== hdl/rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decode
(
    input  rv_core_pkg::word_t    i_inst,
    output rv_core_pkg::decoded_t o_dec
);

import rv_core_pkg::*;

localparam logic [6:0] OP_LUI     = 7'b0110111;
localparam logic [6:0] OP_AUIPC   = 7'b0010111;
localparam logic [6:0] OP_JAL     = 7'b1101111;
localparam logic [6:0] OP_JALR    = 7'b1100111;
localparam logic [6:0] OP_BRANCH  = 7'b1100011;
localparam logic [6:0] OP_LOAD    = 7'b0000011;
localparam logic [6:0] OP_STORE   = 7'b0100011;
localparam logic [6:0] OP_ALU_IMM = 7'b0010011;
localparam logic [6:0] OP_ALU_REG = 7'b0110011;

// wfi with all register fields zero
localparam word_t INST_WFI = 32'h10500073;

logic [6:0] w_opcode;
logic [2:0] w_funct3;
logic [6:0] w_funct7;
word_t      w_imm_i;
word_t      w_imm_s;
word_t      w_imm_b;
word_t      w_imm_u;
word_t      w_imm_j;
alu_op_e    w_alu_op;
logic       w_alu_ok;

assign w_opcode = i_inst[6:0];
assign w_funct3 = i_inst[14:12];
assign w_funct7 = i_inst[31:25];

assign w_imm_i = { { 20 { i_inst[31] } }, i_inst[31:20] };
assign w_imm_s = { { 20 { i_inst[31] } }, i_inst[31:25], i_inst[11:7] };
assign w_imm_b = { { 20 { i_inst[31] } }, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0 };
assign w_imm_u = { i_inst[31:12], 12'b0 };
assign w_imm_j = { { 12 { i_inst[31] } }, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0 };

// opcode bit 5 separates the register group from the immediate group
always_comb
    begin
        case (w_funct3)
            3'b000:
                if (w_opcode[5] && w_funct7[5])
                    w_alu_op = alu_sub;
                else
                    w_alu_op = alu_add;
            3'b001: w_alu_op = alu_sll;
            3'b010: w_alu_op = alu_slt;
            3'b011: w_alu_op = alu_sltu;
            3'b100: w_alu_op = alu_xor;
            3'b101:
                if (w_funct7[5])
                    w_alu_op = alu_sra;
                else
                    w_alu_op = alu_srl;
            3'b110: w_alu_op = alu_or;
            default: w_alu_op = alu_and;
        endcase
    end

always_comb
    begin
        w_alu_ok = 1'b1;
        if (w_opcode[5])
            w_alu_ok = (w_funct7 == 7'h00) ||
                       ((w_funct7 == 7'h20) && ((w_funct3 == 3'b000) || (w_funct3 == 3'b101)));
        else if (w_funct3 == 3'b001)
            w_alu_ok = (w_funct7 == 7'h00);
        else if (w_funct3 == 3'b101)
            w_alu_ok = (w_funct7 == 7'h00) || (w_funct7 == 7'h20);
    end

always_comb
    begin
        o_dec.inst_class = class_invalid;
        o_dec.alu_op     = w_alu_op;
        o_dec.br_cond    = br_eq;
        o_dec.rd         = '0;
        o_dec.rs1        = i_inst[19:15];
        o_dec.rs2        = i_inst[24:20];
        o_dec.imm        = w_imm_i;

        case (w_opcode)
            OP_LUI:
                begin
                    o_dec.inst_class = class_lui;
                    o_dec.imm        = w_imm_u;
                end
            OP_AUIPC:
                begin
                    o_dec.inst_class = class_auipc;
                    o_dec.imm        = w_imm_u;
                end
            OP_JAL:
                begin
                    o_dec.inst_class = class_jal;
                    o_dec.imm        = w_imm_j;
                end
            OP_JALR:
                if (w_funct3 == 3'b000)
                    o_dec.inst_class = class_jalr;
            OP_BRANCH:
                begin
                    o_dec.inst_class = class_branch;
                    o_dec.imm        = w_imm_b;
                    case (w_funct3)
                        3'b000: o_dec.br_cond = br_eq;
                        3'b001: o_dec.br_cond = br_ne;
                        3'b100: o_dec.br_cond = br_lt;
                        3'b101: o_dec.br_cond = br_ge;
                        3'b110: o_dec.br_cond = br_ltu;
                        3'b111: o_dec.br_cond = br_geu;
                        default: o_dec.inst_class = class_invalid;
                    endcase
                end
            OP_LOAD:
                if (w_funct3 == 3'b010)
                    o_dec.inst_class = class_load;
            OP_STORE:
                begin
                    o_dec.imm = w_imm_s;
                    if (w_funct3 == 3'b010)
                        o_dec.inst_class = class_store;
                end
            OP_ALU_IMM:
                if (w_alu_ok)
                    o_dec.inst_class = class_alu_imm;
            OP_ALU_REG:
                if (w_alu_ok)
                    o_dec.inst_class = class_alu_reg;
            default:
                if (i_inst == INST_WFI)
                    o_dec.inst_class = class_wfi;
        endcase

        if (!(o_dec.inst_class inside {class_branch, class_store, class_wfi, class_invalid}))
            o_dec.rd = i_inst[11:7];
    end

endmodule

`default_nettype wire

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
(
    input  logic                  i_clk,

    input  rv_core_pkg::reg_idx_t i_rs1,
    input  rv_core_pkg::reg_idx_t i_rs2,
    output rv_core_pkg::word_t    o_rs1_val,
    output rv_core_pkg::word_t    o_rs2_val,

    input  logic                  i_we,
    input  rv_core_pkg::reg_idx_t i_rd,
    input  rv_core_pkg::word_t    i_rd_val
);

import rv_core_pkg::*;

// x0 has no storage
word_t r_regs [1:31];

assign o_rs1_val = (i_rs1 == '0) ? '0 : r_regs[i_rs1];
assign o_rs2_val = (i_rs2 == '0) ? '0 : r_regs[i_rs2];

always_ff @ (posedge i_clk)
    if (i_we && (i_rd != '0))
        begin
            r_regs[i_rd] <= i_rd_val;
        end

endmodule

`default_nettype wire

// ==== hdl/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_alu
(
    input  rv_core_pkg::decoded_t i_dec,
    input  rv_core_pkg::addr_t    i_pc,
    input  rv_core_pkg::word_t    i_rs1_val,
    input  rv_core_pkg::word_t    i_rs2_val,

    output rv_core_pkg::word_t    o_result,
    output logic                  o_taken,
    output rv_core_pkg::addr_t    o_ea
);

import rv_core_pkg::*;

word_t      w_op_b;
logic [4:0] w_shamt;
word_t      w_alu_out;
logic       w_cond;
addr_t      w_sum;

assign w_op_b  = (i_dec.inst_class == class_alu_reg) ? i_rs2_val : i_dec.imm;
assign w_shamt = w_op_b[4:0];

always_comb
    begin
        case (i_dec.alu_op)
            alu_add:  w_alu_out = i_rs1_val + w_op_b;
            alu_sub:  w_alu_out = i_rs1_val - w_op_b;
            alu_sll:  w_alu_out = i_rs1_val << w_shamt;
            alu_slt:  w_alu_out = word_t'($signed(i_rs1_val) < $signed(w_op_b));
            alu_sltu: w_alu_out = word_t'(i_rs1_val < w_op_b);
            alu_xor:  w_alu_out = i_rs1_val ^ w_op_b;
            alu_srl:  w_alu_out = i_rs1_val >> w_shamt;
            alu_sra:  w_alu_out = word_t'($signed(i_rs1_val) >>> w_shamt);
            alu_or:   w_alu_out = i_rs1_val | w_op_b;
            default:  w_alu_out = i_rs1_val & w_op_b;
        endcase
    end

// branches always compare the two registers
always_comb
    begin
        case (i_dec.br_cond)
            br_eq:   w_cond = (i_rs1_val == i_rs2_val);
            br_ne:   w_cond = (i_rs1_val != i_rs2_val);
            br_lt:   w_cond = ($signed(i_rs1_val) < $signed(i_rs2_val));
            br_ge:   w_cond = ($signed(i_rs1_val) >= $signed(i_rs2_val));
            br_ltu:  w_cond = (i_rs1_val < i_rs2_val);
            default: w_cond = (i_rs1_val >= i_rs2_val);
        endcase
    end

assign o_taken = (i_dec.inst_class == class_branch) && w_cond;

always_comb
    begin
        case (i_dec.inst_class)
            class_lui:   o_result = i_dec.imm;
            class_auipc: o_result = i_pc + i_dec.imm;
            class_jal,
            class_jalr:  o_result = i_pc + 32'd4;
            default:     o_result = w_alu_out;
        endcase
    end

// load/store address, or jalr target with bit 0 cleared
assign w_sum = i_rs1_val + i_dec.imm;
assign o_ea  = (i_dec.inst_class == class_jalr) ? { w_sum[XLEN-1:1], 1'b0 } : w_sum;

endmodule

`default_nettype wire

// ==== hdl/rv_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_control
#(
    parameter rv_core_pkg::addr_t RESET_PC = '0
)
(
    input  logic                  i_clk,
    input  logic                  i_rst,

    input  logic                  i_start,
    output logic                  o_idle,

    output rv_core_pkg::word_t    o_inst,
    input  rv_core_pkg::decoded_t i_dec,
    input  rv_core_pkg::word_t    i_rs2_val,

    input  rv_core_pkg::word_t    i_result,
    input  logic                  i_taken,
    input  rv_core_pkg::addr_t    i_ea,
    output rv_core_pkg::addr_t    o_pc,

    output logic                  o_rd_we,
    output rv_core_pkg::reg_idx_t o_rd,
    output rv_core_pkg::word_t    o_rd_val,

    output rv_core_pkg::wb_m2s_t  o_wb,
    input  rv_core_pkg::wb_s2m_t  i_wb
);

import rv_core_pkg::*;

core_state_e r_state;
addr_t       r_pc;
word_t       r_inst;
wb_m2s_t     r_wb;
addr_t       w_target;
addr_t       w_next_pc;

function automatic wb_m2s_t wb_request(input logic we, input addr_t adr, input word_t dat);
    wb_m2s_t req;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = dat;
    return req;
endfunction

// jal and branches share the pc relative adder
assign w_target = r_pc + i_dec.imm;

always_comb
    begin
        case (i_dec.inst_class)
            class_jal:    w_next_pc = w_target;
            class_jalr:   w_next_pc = i_ea;
            class_branch: w_next_pc = i_taken ? w_target : (r_pc + 32'd4);
            default:      w_next_pc = r_pc + 32'd4;
        endcase
    end

assign o_idle = (r_state == state_idle);
assign o_inst = r_inst;
assign o_pc   = r_pc;
assign o_wb   = r_wb;

// load data lands in rd in the ack cycle
assign o_rd     = i_dec.rd;
assign o_rd_we  = ((r_state == state_execute) && (i_dec.inst_class != class_load)) ||
                  ((r_state == state_load) && i_wb.ack);
assign o_rd_val = (r_state == state_load) ? i_wb.dat : i_result;

always_ff @ (posedge i_clk)
    if (i_rst)
        begin
            r_state  <= state_idle;
            r_pc     <= RESET_PC;
            r_wb.cyc <= 1'b0;
            r_wb.stb <= 1'b0;
            r_wb.we  <= 1'b0;
        end
    else
        begin
            case (r_state)
                state_idle:
                    if (i_start)
                        begin
                            // each run starts again from the reset vector
                            r_pc    <= RESET_PC;
                            r_wb    <= wb_request(1'b0, RESET_PC, '0);
                            r_state <= state_fetch;
                        end
                state_fetch:
                    if (!r_wb.cyc)
                        begin
                            // bus was released after a load or store
                            r_wb <= wb_request(1'b0, r_pc, '0);
                        end
                    else if (i_wb.ack)
                        begin
                            r_inst   <= i_wb.dat;
                            r_wb.cyc <= 1'b0;
                            r_wb.stb <= 1'b0;
                            r_state  <= state_execute;
                        end
                state_execute:
                    case (i_dec.inst_class)
                        class_load:
                            begin
                                r_pc    <= w_next_pc;
                                r_wb    <= wb_request(1'b0, i_ea, '0);
                                r_state <= state_load;
                            end
                        class_store:
                            begin
                                r_pc    <= w_next_pc;
                                r_wb    <= wb_request(1'b1, i_ea, i_rs2_val);
                                r_state <= state_store;
                            end
                        class_wfi,
                        class_invalid:
                            r_state <= state_idle;
                        default:
                            begin
                                r_pc    <= w_next_pc;
                                r_wb    <= wb_request(1'b0, w_next_pc, '0);
                                r_state <= state_fetch;
                            end
                    endcase
                state_load,
                state_store:
                    if (i_wb.ack)
                        begin
                            r_wb.cyc <= 1'b0;
                            r_wb.stb <= 1'b0;
                            r_state  <= state_fetch;
                        end
                default:
                    r_state <= state_idle;
            endcase
        end

endmodule

`default_nettype wire

// ==== hdl/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core
#(
    parameter rv_core_pkg::addr_t RESET_PC = '0
)
(
    input  logic                 i_clk,
    input  logic                 i_rst,

    input  logic                 i_start,
    output logic                 o_idle,

    output rv_core_pkg::wb_m2s_t o_wb,
    input  rv_core_pkg::wb_s2m_t i_wb
);

import rv_core_pkg::*;

word_t    w_inst;
decoded_t w_dec;
word_t    w_rs1_val;
word_t    w_rs2_val;
word_t    w_result;
logic     w_taken;
addr_t    w_ea;
addr_t    w_pc;
logic     w_rd_we;
reg_idx_t w_rd;
word_t    w_rd_val;

rv_control
#(
    .RESET_PC(RESET_PC)
)
rv_control_inst
(
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_start(i_start),
    .o_idle(o_idle),
    .o_inst(w_inst),
    .i_dec(w_dec),
    .i_rs2_val(w_rs2_val),
    .i_result(w_result),
    .i_taken(w_taken),
    .i_ea(w_ea),
    .o_pc(w_pc),
    .o_rd_we(w_rd_we),
    .o_rd(w_rd),
    .o_rd_val(w_rd_val),
    .o_wb(o_wb),
    .i_wb(i_wb)
);

rv_decode rv_decode_inst
(
    .i_inst(w_inst),
    .o_dec(w_dec)
);

rv_regfile rv_regfile_inst
(
    .i_clk(i_clk),
    .i_rs1(w_dec.rs1),
    .i_rs2(w_dec.rs2),
    .o_rs1_val(w_rs1_val),
    .o_rs2_val(w_rs2_val),
    .i_we(w_rd_we),
    .i_rd(w_rd),
    .i_rd_val(w_rd_val)
);

rv_alu rv_alu_inst
(
    .i_dec(w_dec),
    .i_pc(w_pc),
    .i_rs1_val(w_rs1_val),
    .i_rs2_val(w_rs2_val),
    .o_result(w_result),
    .o_taken(w_taken),
    .o_ea(w_ea)
);

endmodule

`default_nettype wire

// ==== tests/rv_wb_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_wb_mem
(
    input  logic                 i_clk,
    input  logic                 i_rst,

    input  rv_core_pkg::wb_m2s_t i_wb,
    output rv_core_pkg::wb_s2m_t o_wb,

    output int                   o_write_count,
    output rv_core_pkg::addr_t   o_last_adr,
    output rv_core_pkg::word_t   o_last_dat
);

import rv_core_pkg::*;

word_t       r_mem [0:255];
addr_t       r_log_adr [0:7];
word_t       r_log_dat [0:7];
int          r_count;
logic        r_busy;
logic [1:0]  r_wait;
logic [31:0] r_rnd;
integer      seed = 32'h84f1bb05;

// fill with the byte address so stray reads are easy to spot
initial
    begin
        for (int i = 0; i < 256; i++)
            r_mem[i] = 32'hbad0_0000 | (i << 2);
    end

assign o_write_count = r_count;
assign o_last_adr    = r_log_adr[3'(r_count - 1)];
assign o_last_dat    = r_log_dat[3'(r_count - 1)];

always @(posedge i_clk)
    if (i_rst)
        begin
            o_wb.ack <= 1'b0;
            r_busy   <= 1'b0;
            r_count  <= 0;
        end
    else if (o_wb.ack)
        o_wb.ack <= 1'b0;
    else if (i_wb.cyc && i_wb.stb)
        begin
            if (!r_busy)
                begin
                    // new request, draw 0 to 3 wait states
                    r_rnd = $random(seed);
                    r_wait <= r_rnd[1:0];
                    r_busy <= 1'b1;
                end
            else if (r_wait != 2'd0)
                r_wait <= r_wait - 2'd1;
            else
                begin
                    o_wb.ack <= 1'b1;
                    o_wb.dat <= r_mem[i_wb.adr[9:2]];
                    r_busy   <= 1'b0;
                    if (i_wb.we)
                        begin
                            r_mem[i_wb.adr[9:2]]      <= i_wb.dat;
                            r_log_adr[r_count[2:0]] <= i_wb.adr;
                            r_log_dat[r_count[2:0]] <= i_wb.dat;
                            r_count                 <= r_count + 1;
                        end
                end
        end

endmodule

`default_nettype wire

// ==== tests/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

import rv_core_pkg::*;

typedef logic [0:11][31:0] prog_t;

logic    i_clk;
logic    i_rst;
logic    i_start;
logic    o_idle;
wb_m2s_t o_wb;
wb_s2m_t i_wb;
int      write_count;
addr_t   last_adr;
word_t   last_dat;

prog_t   prog_tab [$];
addr_t   exp_adr_q [$];
word_t   exp_dat_q [$];
int      errors = 0;
int      cycles = 0;
int      limit = 100;
int      count_before;
int      count_idle;

rv_core #(.RESET_PC(32'h0)) DUT
(
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_start(i_start),
    .o_idle(o_idle),
    .o_wb(o_wb),
    .i_wb(i_wb)
);

rv_wb_mem mem_inst
(
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_wb(o_wb),
    .o_wb(i_wb),
    .o_write_count(write_count),
    .o_last_adr(last_adr),
    .o_last_dat(last_dat)
);

initial i_clk = 1'b0;
always #10 i_clk = ~i_clk;

always @(posedge i_clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= limit)
            begin
                $display("timeout: the core never returned to idle after %0d cycles", cycles);
                $display("Checks failed");
                $finish;
            end
    end

task automatic add_row(input prog_t prog, input addr_t adr, input word_t dat);
    prog_tab.push_back(prog);
    exp_adr_q.push_back(adr);
    exp_dat_q.push_back(dat);
endtask

task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp)
        begin
            $display("[ERROR] %0t %s: address %h, expected %h", $time, what, got, exp);
            errors++;
        end
endtask

task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp)
        begin
            $display("[ERROR] %0t %s: data %h, expected %h", $time, what, got, exp);
            errors++;
        end
endtask

task automatic check_idle(input logic got, input logic exp, input string what);
    if (got !== exp)
        begin
            $display("[ERROR] %0t %s: o_idle %b, expected %b", $time, what, got, exp);
            errors++;
        end
endtask

initial
    begin
        i_rst   = 1'b1;
        i_start = 1'b0;

        // alu groups, lui/auipc, branches, jumps, load/store, ecall
        add_row({32'hFFB00093, 32'h00300113, 32'h402081B3, 32'h10302023, 32'h10500073,
                 32'h10302223, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0}, 32'h100, 32'hFFFFFFF8);
        add_row({32'hFFB00093, 32'h00300113, 32'h0020A1B3, 32'h0020B233, 32'h00119193,
                 32'h0041E1B3, 32'h10302023, 32'h10500073, 32'h0, 32'h0, 32'h0, 32'h0},
                32'h100, 32'h00000002);
        add_row({32'hFF000093, 32'h02100113, 32'h4020D1B3, 32'h0020D233, 32'h004181B3,
                 32'h002092B3, 32'h0051C1B3, 32'h10302023, 32'h10500073, 32'h0, 32'h0,
                 32'h0}, 32'h100, 32'h80000010);
        add_row({32'h7F000093, 32'hFFF0C113, 32'h40415193, 32'h0F01F193, 32'h0051E193,
                 32'h00012213, 32'h00113293, 32'h00821213, 32'h004181B3, 32'h005181B3,
                 32'h10302023, 32'h10500073}, 32'h100, 32'h00000185);
        add_row({32'h123450B7, 32'h00001117, 32'h002081B3, 32'h10302023, 32'h10500073,
                 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0}, 32'h100, 32'h12346004);
        // beq/bne/blt and bge/bltu/bgeu with x1 below x2, equal, and 1 against -1
        add_row({32'hFFF00093, 32'h00100113, 32'h00000193, 32'h00208463, 32'h00118193,
                 32'h00209463, 32'h00218193, 32'h0020C463, 32'h00418193, 32'h10302023,
                 32'h10500073, 32'h0}, 32'h100, 32'h00000001);
        add_row({32'hFFF00093, 32'h00100113, 32'h00000193, 32'h0020D463, 32'h00118193,
                 32'h0020E463, 32'h00218193, 32'h0020F463, 32'h00418193, 32'h10302023,
                 32'h10500073, 32'h0}, 32'h100, 32'h00000003);
        add_row({32'h00100093, 32'h00100113, 32'h00000193, 32'h00208463, 32'h00118193,
                 32'h00209463, 32'h00218193, 32'h0020C463, 32'h00418193, 32'h10302023,
                 32'h10500073, 32'h0}, 32'h100, 32'h00000006);
        add_row({32'h00100093, 32'hFFF00113, 32'h00000193, 32'h0020D463, 32'h00118193,
                 32'h0020E463, 32'h00218193, 32'h0020F463, 32'h00418193, 32'h10302023,
                 32'h10500073, 32'h0}, 32'h100, 32'h00000004);
        add_row({32'h008000EF, 32'h05500093, 32'h00C08167, 32'h06600113, 32'h00811113,
                 32'h002081B3, 32'h10302023, 32'h10500073, 32'h0, 32'h0, 32'h0, 32'h0},
                32'h100, 32'h00000C04);
        add_row({32'h5A500093, 32'h00C09093, 32'h0C308093, 32'h10102423, 32'h10802183,
                 32'h10302023, 32'h10500073, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
                32'h100, 32'h005A50C3);
        add_row({32'h07700193, 32'h10302023, 32'h00000073, 32'h10302223, 32'h10500073,
                 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0}, 32'h100, 32'h00000077);

        limit = prog_tab.size() * 12 * 2 * 5 + 100;

        repeat (5) @(posedge i_clk);
        i_rst <= 1'b0;
        @(negedge i_clk);
        check_idle(o_idle, 1'b1, "after reset");

        for (int r = 0; r < prog_tab.size(); r++)
            begin
                for (int w = 0; w < 12; w++)
                    mem_inst.r_mem[w] = prog_tab[r][w];
                count_before = write_count;
                @(posedge i_clk);
                i_start <= 1'b1;
                @(posedge i_clk);
                i_start <= 1'b0;
                @(negedge i_clk);
                check_idle(o_idle, 1'b0, "after start");
                while (!o_idle)
                    @(negedge i_clk);
                count_idle = write_count;
                if (count_idle == count_before)
                    begin
                        $display("row %0d finished without any memory write", r);
                        errors++;
                    end
                check_addr(last_adr, exp_adr_q[r], $sformatf("row %0d store", r));
                check_word(last_dat, exp_dat_q[r], $sformatf("row %0d store", r));
                repeat (10) @(negedge i_clk);
                if (write_count != count_idle)
                    begin
                        $display("row %0d wrote memory after the core went idle", r);
                        errors++;
                    end
                check_idle(o_idle, 1'b1, $sformatf("row %0d end", r));
            end

        $display("rows: %0d, errors: %0d", prog_tab.size(), errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_core.f ====
hdl/rv_core_pkg.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_control.sv
hdl/rv_core.sv
tests/rv_wb_mem.sv
tests/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - hdl/rv_core_pkg.sv
  - hdl/rv_decode.sv
  - hdl/rv_regfile.sv
  - hdl/rv_alu.sv
  - hdl/rv_control.sv
  - hdl/rv_core.sv
  - target: test
    files:
      - tests/rv_wb_mem.sv
      - tests/rv_core_tb.sv
